/* common/duc_pkg.sv */
`default_nettype none

package duc_pkg;

   // Bit widths of the datapath words
   localparam int SAMPLE_W = 18;
   localparam int COEFF_W  = 18;
   localparam int PRESUM_W = SAMPLE_W + 1;
   localparam int PROD_W   = COEFF_W + PRESUM_W;
   localparam int ACC_W    = PROD_W + 2;
   localparam int RATE_W   = 8;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [COEFF_W-1:0]  coeff_t;
   typedef logic signed [PRESUM_W-1:0] presum_t;
   typedef logic signed [PROD_W-1:0]   prod_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic        [RATE_W-1:0]   rate_t;

   // Shortest output period the MAC and rounding pipeline can keep up with
   localparam rate_t RATE_MIN = 8'd6;

   // Halfband taps A 0 B 0 C 0 D 0.5 D 0 C 0 B 0 A, centre tap is 2^17
   localparam coeff_t COEFF_A = -18'sd597;
   localparam coeff_t COEFF_B = 18'sd4283;
   localparam coeff_t COEFF_C = -18'sd17516;
   localparam coeff_t COEFF_D = 18'sd79365;
   localparam int     COEFF_SHIFT = 17;

   // Saturation limits of the output sample
   localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
   localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

   // Strobes shared by all channels, all from the rate unit
   typedef struct packed {
      logic stb_in;
      logic stb_out;
      logic bypass;
   } hb_ctrl_t;

   // Even outputs repeat the centre sample, odd outputs are filtered
   typedef enum logic {
      PHASE_EVEN = 1'b0,
      PHASE_ODD  = 1'b1
   } phase_t;

endpackage

`default_nettype wire

/* hb_interp/hb_interp.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_interp
   import duc_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n,
   input  wire hb_ctrl_t ctrl,
   input  wire sample_t  in_sample,
   output sample_t       out_sample
);

   // Input history, dly[0] holds x[k-1] while x[k] sits on in_sample
   // The live input acts as the newest of the eight filter taps
   sample_t       dly [0:6];
   // Symmetric pair sums for A, B, C and D in index order 0 to 3
   presum_t [3:0] pair_q;
   logic          start_q;
   acc_t          mac_acc;
   logic          mac_done;
   sample_t       rnd_sample;
   // Marks the cycle in which the rounded odd result is on rnd_sample
   logic          rnd_vld_q;
   // Odd phase result kept for the middle output strobe
   sample_t       odd_q;

   // Delay line shifts on each accepted sample
   // Zeroed at reset so that samples before the first one count as zero
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 7; i++)
         begin
            dly[i] <= '0;
         end
      end
      else if (ctrl.stb_in)
      begin
         dly[0] <= in_sample;
         for (int i = 1; i < 7; i++)
         begin
            dly[i] <= dly[i-1];
         end
      end
   end

   // Pair sums are formed in the same edge that shifts the line,
   // from the live input and the values the line holds before the shift
   // Full precision with one guard bit, no rounding here
   always_ff @(posedge clk)
   begin
      if (ctrl.stb_in)
      begin
         pair_q[0] <= presum_t'(in_sample) + presum_t'(dly[6]);
         pair_q[1] <= presum_t'(dly[0]) + presum_t'(dly[5]);
         pair_q[2] <= presum_t'(dly[1]) + presum_t'(dly[4]);
         pair_q[3] <= presum_t'(dly[2]) + presum_t'(dly[3]);
      end
   end

   // The MAC starts in the cycle after the pair sums are loaded
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_q   <= 1'b0;
         rnd_vld_q <= 1'b0;
      end
      else
      begin
         start_q   <= ctrl.stb_in;
         rnd_vld_q <= mac_done;
      end
   end

   hb_mac u_mac (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start_q),
      .pair_ad (pair_q),
      .acc     (mac_acc),
      .done    (mac_done)
   );

   round_clip u_round (
      .clk        (clk),
      .rst_n      (rst_n),
      .acc_in     (mac_acc),
      .out_sample (rnd_sample)
   );

   // Result is ready four cycles after stb_in, well before the odd strobe
   always_ff @(posedge clk)
   begin
      if (rnd_vld_q)
      begin
         odd_q <= rnd_sample;
      end
   end

   // Output phase selection at each output strobe
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_sample <= '0;
      end
      else if (ctrl.stb_out)
      begin
         if (ctrl.bypass)
         begin
            // Newest accepted sample, which may be arriving right now
            out_sample <= ctrl.stb_in ? in_sample : dly[0];
         end
         else if (ctrl.stb_in)
         begin
            // Even phase is the centre tap x[k-4] at gain one
            out_sample <= dly[3];
         end
         else
         begin
            out_sample <= odd_q;
         end
      end
   end

endmodule

`default_nettype wire

/* hb_interp/hb_mac.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_mac
   import duc_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire logic          start,
   input  wire presum_t [3:0] pair_ad,
   output acc_t               acc,
   output logic               done
);

   // High in the second cycle of a conversion
   logic    second_q;
   coeff_t  coef_lo;
   coeff_t  coef_hi;
   presum_t sum_lo;
   presum_t sum_hi;
   prod_t   prod_lo;
   prod_t   prod_hi;

   // First cycle feeds A and C, the second cycle feeds B and D
   assign coef_lo = second_q ? COEFF_B : COEFF_A;
   assign sum_lo  = second_q ? pair_ad[1] : pair_ad[0];
   assign coef_hi = second_q ? COEFF_D : COEFF_C;
   assign sum_hi  = second_q ? pair_ad[3] : pair_ad[2];

   // Two multipliers, each used twice per conversion
   assign prod_lo = coef_lo * sum_lo;
   assign prod_hi = coef_hi * sum_hi;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         second_q <= 1'b0;
         done     <= 1'b0;
      end
      else
      begin
         second_q <= start;
         done     <= second_q;
      end
   end

   // The start cycle clears the sum by loading it, the next cycle adds
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         acc <= acc_t'(prod_lo) + acc_t'(prod_hi);
      end
      else if (second_q)
      begin
         acc <= acc + acc_t'(prod_lo) + acc_t'(prod_hi);
      end
   end

endmodule

`default_nettype wire

/* logic/duc_hb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module duc_hb_top
   import duc_pkg::*;
#(
   parameter int NUM_CHAN = 2
)
(
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire rate_t                        rate,
   input  wire logic                         bypass,
   input  wire logic [NUM_CHAN*SAMPLE_W-1:0] in_data,
   output logic                              in_req,
   output logic [NUM_CHAN*SAMPLE_W-1:0]      out_data,
   output phase_t                            out_phase,
   output logic                              out_valid
);

   // Strobes common to all channels
   hb_ctrl_t                     ctrl;
   // Interpolator outputs, channel 0 in the low bits
   logic [NUM_CHAN*SAMPLE_W-1:0] chan_samples;

   rate_strobe_gen u_rate (
      .clk    (clk),
      .rst_n  (rst_n),
      .rate   (rate),
      .bypass (bypass),
      .ctrl   (ctrl)
   );

   // The source must present the next samples before this pulse
   assign in_req = ctrl.stb_in;

   // One halfband interpolator per channel
   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_chan
      hb_interp u_hb (
         .clk        (clk),
         .rst_n      (rst_n),
         .ctrl       (ctrl),
         .in_sample  (in_data[i*SAMPLE_W +: SAMPLE_W]),
         .out_sample (chan_samples[i*SAMPLE_W +: SAMPLE_W])
      );
   end

   sample_gather #(
      .NUM_CHAN (NUM_CHAN)
   ) u_gather (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctrl         (ctrl),
      .chan_samples (chan_samples),
      .out_data     (out_data),
      .out_phase    (out_phase),
      .out_valid    (out_valid)
   );

endmodule

`default_nettype wire

/* logic/rate_strobe_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module rate_strobe_gen
   import duc_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n,
   input  wire rate_t    rate,
   input  wire logic     bypass,
   output hb_ctrl_t      ctrl
);

   // Period after clamping to what the pipeline allows
   rate_t per_clamp;
   // Cycles left in the current period, zero only right after reset
   rate_t cnt_q;
   // High when the next output strobe is an odd one
   logic  odd_q;
   logic  period_end;

   assign per_clamp  = (rate < RATE_MIN) ? RATE_MIN : rate;
   assign period_end = (cnt_q == rate_t'(1));

   // Down counter over the clamped period
   // The first period after reset is one cycle short in the counter,
   // because the reset state itself counts as the load cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt_q <= '0;
      end
      else if (cnt_q == '0)
      begin
         cnt_q <= per_clamp - rate_t'(1);
      end
      else if (period_end)
      begin
         // A new period starts here, so the rate level is sampled now
         cnt_q <= per_clamp;
      end
      else
      begin
         cnt_q <= cnt_q - rate_t'(1);
      end
   end

   // Strobes are registered so that every channel sees them in the same cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         odd_q <= 1'b0;
         ctrl  <= '0;
      end
      else
      begin
         ctrl.stb_out <= period_end;
         // Every second output strobe also takes a new input sample
         ctrl.stb_in  <= period_end && !odd_q;
         ctrl.bypass  <= bypass;
         if (period_end)
         begin
            odd_q <= !odd_q;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/round_clip.sv */
`timescale 1ns/10ps
`default_nettype none

module round_clip
   import duc_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire acc_t  acc_in,
   output sample_t    out_sample
);

   // Width left after dropping the fraction bits
   localparam int QUOT_W = ACC_W - COEFF_SHIFT;
   // Half of one output LSB in accumulator units
   localparam acc_t HALF_LSB = acc_t'(1) << (COEFF_SHIFT - 1);

   acc_t                     rnd_sum;
   logic signed [QUOT_W-1:0] quot;
   // Bits above the sample sign, must all equal it for the value to fit
   logic [QUOT_W-SAMPLE_W:0] top_bits;
   logic                     fits;

   assign rnd_sum  = acc_in + HALF_LSB;
   // Arithmetic shift gives floor, so this is round half up
   assign quot     = rnd_sum[ACC_W-1:COEFF_SHIFT];
   assign top_bits = quot[QUOT_W-1:SAMPLE_W-1];
   assign fits     = (&top_bits) || !(|top_bits);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_sample <= '0;
      end
      else if (fits)
      begin
         out_sample <= quot[SAMPLE_W-1:0];
      end
      else
      begin
         // Saturate toward the sign of the true result
         out_sample <= quot[QUOT_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
      end
   end

endmodule

`default_nettype wire

/* logic/sample_gather.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_gather
   import duc_pkg::*;
#(
   parameter int NUM_CHAN = 2
)
(
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire hb_ctrl_t                     ctrl,
   input  wire logic [NUM_CHAN*SAMPLE_W-1:0] chan_samples,
   output logic [NUM_CHAN*SAMPLE_W-1:0]      out_data,
   output phase_t                            out_phase,
   output logic                              out_valid
);

   // Channel outputs settle one cycle after stb_out, hence the delay
   logic stb_out_d;
   logic stb_in_d;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         stb_out_d <= 1'b0;
         stb_in_d  <= 1'b0;
         out_valid <= 1'b0;
         out_data  <= '0;
         out_phase <= PHASE_EVEN;
      end
      else
      begin
         stb_out_d <= ctrl.stb_out;
         stb_in_d  <= ctrl.stb_in;
         out_valid <= stb_out_d;
         if (stb_out_d)
         begin
            // All channels are taken in the same cycle
            out_data  <= chan_samples;
            // A strobe that also took an input is an even one
            out_phase <= stb_in_d ? PHASE_EVEN : PHASE_ODD;
         end
      end
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verif
common/duc_pkg.sv
logic/rate_strobe_gen.sv
logic/round_clip.sv
hb_interp/hb_mac.sv
hb_interp/hb_interp.sv
logic/sample_gather.sv
logic/duc_hb_top.sv
verif/tb_duc_hb.sv

/* verif/hb_ref_model.svh */
`ifndef HB_REF_MODEL_SVH
`define HB_REF_MODEL_SVH

// Reference model of the halfband interpolator, included in the testbench module
// NUM_CHAN must be declared before this file is included

// Outer taps of the reference filter, the centre tap is 2^17
localparam int REF_A = -597;
localparam int REF_B = 4283;
localparam int REF_C = -17516;
localparam int REF_D = 79365;

// hist[c][j] holds x[k-j] of channel c, zero before the first accepted sample
int hist [0:NUM_CHAN-1][0:7];
// Number of odd outputs the model had to saturate
int sat_hits = 0;

// Shifts a newly accepted sample into the channel history
function automatic void hist_push(int ch, int x);
   for (int j = 7; j > 0; j--)
   begin
      hist[ch][j] = hist[ch][j-1];
   end
   hist[ch][0] = x;
endfunction

// Adds half an LSB and divides by 2^17, the arithmetic shift rounds toward minus infinity
function automatic longint round_half_up(longint acc);
   return (acc + 64'sd65536) >>> 17;
endfunction

// Limits a value to the 18 bit signed range
function automatic longint clip_sample(longint v);
   if (v > 131071)
      return 131071;
   if (v < -131072)
      return -131072;
   return v;
endfunction

// Half-sample value from the eight newest inputs, before saturation
function automatic longint halfband_odd(int ch);
   longint sum;
   sum = longint'(REF_A) * longint'(hist[ch][0] + hist[ch][7])
       + longint'(REF_B) * longint'(hist[ch][1] + hist[ch][6])
       + longint'(REF_C) * longint'(hist[ch][2] + hist[ch][5])
       + longint'(REF_D) * longint'(hist[ch][3] + hist[ch][4]);
   return round_half_up(sum);
endfunction

// Expected channel output for one output strobe
function automatic int expected_sample(int ch, bit odd, bit byp);
   longint v;
   // Bypass repeats the last accepted sample in both phases
   if (byp)
      return hist[ch][0];
   // Even phase is the delayed centre sample
   if (!odd)
      return hist[ch][4];
   v = halfband_odd(ch);
   if (clip_sample(v) != v)
      sat_hits++;
   return int'(clip_sample(v));
endfunction

`endif

/* verif/tb_duc_hb.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_duc_hb
   import duc_pkg::*;
();

   localparam int NUM_CHAN = 2;
   localparam int W = NUM_CHAN * SAMPLE_W;

   logic         clk;
   logic         rst_n;
   rate_t        rate;
   logic         bypass;
   logic [W-1:0] in_data;
   logic         in_req;
   logic [W-1:0] out_data;
   phase_t       out_phase;
   logic         out_valid;

   int           seed;
   // Cycle counter and event counts kept at every falling edge
   int           cycle_cnt;
   int           valid_cnt;
   int           req_cnt;
   int           last_valid_cyc;
   int           last_req_cyc;
   // Expected output period, zero while the rate is changing
   int           exp_per;
   bit           exp_odd;
   bit           model_byp;
   bit           load_pending;
   // Input words waiting for the next in_req
   logic [W-1:0] feed_q [$];

   `include "hb_ref_model.svh"

   duc_hb_top #(
      .NUM_CHAN (NUM_CHAN)
   ) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .rate      (rate),
      .bypass    (bypass),
      .in_data   (in_data),
      .in_req    (in_req),
      .out_data  (out_data),
      .out_phase (out_phase),
      .out_valid (out_valid)
   );

   always #4 clk = ~clk;

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_value(string name, longint got, longint expected);
      assert (got == expected)
      else
         report_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h",
                                  name, got, expected));
   endtask

   // Nothing may leave the DUT before the first strobe
   task automatic check_reset_state();
      check_value("in_req", in_req, 0);
      check_value("out_valid", out_valid, 0);
      check_value("out_data", out_data, 0);
   endtask

   // Everything that happens at one falling edge: loading, history and output checks
   task automatic service_cycle();
      sample_t s;
      cycle_cnt++;
      if (load_pending)
      begin
         load_pending = 1'b0;
         if (feed_q.size() > 0)
            in_data = feed_q.pop_front();
         else
            in_data = '0;
      end
      if (in_req)
      begin
         // The DUT takes the word now on in_data at the coming rising edge
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            s = in_data[c*SAMPLE_W +: SAMPLE_W];
            hist_push(c, s);
         end
         if (exp_per != 0 && req_cnt > 0)
            check_value("in_req spacing", cycle_cnt - last_req_cyc, 2 * exp_per);
         last_req_cyc = cycle_cnt;
         req_cnt++;
         load_pending = 1'b1;
      end
      if (out_valid)
      begin
         check_value("out_phase", out_phase, exp_odd ? PHASE_ODD : PHASE_EVEN);
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            s = out_data[c*SAMPLE_W +: SAMPLE_W];
            check_value($sformatf("out_data ch%0d", c), s, expected_sample(c, exp_odd, model_byp));
         end
         if (exp_per != 0 && valid_cnt > 0)
            check_value("out_valid spacing", cycle_cnt - last_valid_cyc, exp_per);
         last_valid_cyc = cycle_cnt;
         valid_cnt++;
         exp_odd = !exp_odd;
      end
   endtask

   task automatic next_cycle();
      @(negedge clk);
      service_cycle();
   endtask

   task automatic wait_outputs(int n);
      int target;
      int limit;
      target = valid_cnt + n;
      limit  = n * 520 + 20;
      while (valid_cnt < target)
      begin
         if (limit == 0)
            report_failure("Timeout while waiting for out_valid");
         else
         begin
            limit--;
            next_cycle();
         end
      end
   endtask

   task automatic wait_inputs(int n);
      int target;
      int limit;
      target = req_cnt + n;
      limit  = n * 520 + 20;
      while (req_cnt < target)
      begin
         if (limit == 0)
            report_failure("Timeout while waiting for in_req");
         else
         begin
            limit--;
            next_cycle();
         end
      end
   endtask

   // Feeds every queued word and waits for both outputs of the last one
   task automatic drain();
      wait_inputs(feed_q.size() + 1);
      wait_outputs(2);
   endtask

   task automatic push_random(int n);
      logic [W-1:0] w;
      int           r;
      for (int i = 0; i < n; i++)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            r = $random(seed);
            w[c*SAMPLE_W +: SAMPLE_W] = r[SAMPLE_W-1:0];
         end
         feed_q.push_back(w);
      end
   endtask

   task automatic push_const(int n, int v0, int v1);
      logic [W-1:0] w;
      w[0 +: SAMPLE_W]        = sample_t'(v0);
      w[SAMPLE_W +: SAMPLE_W] = sample_t'(v1);
      repeat (n)
         feed_q.push_back(w);
   endtask

   // The old period finishes first, so spacing is checked again after three outputs
   task automatic set_rate(rate_t r);
      rate    = r;
      exp_per = 0;
      wait_outputs(3);
      exp_per = (r < 6) ? 6 : r;
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      rate = 8'd10;
      bypass = 1'b0;
      in_data = '0;
      seed = 14;
      cycle_cnt = 0;
      valid_cnt = 0;
      req_cnt = 0;
      last_valid_cyc = 0;
      last_req_cyc = 0;
      exp_per = 10;
      exp_odd = 1'b0;
      model_byp = 1'b0;
      load_pending = 1'b0;
      repeat (10)
      begin
         @(negedge clk);
         check_reset_state();
      end
      rst_n = 1'b1;
      // The first strobe comes one full period after reset is released
      cycle_cnt = 0;
      while (!in_req)
      begin
         if (cycle_cnt > 20)
            report_failure("Timeout while waiting for the first in_req after reset");
         else
         begin
            next_cycle();
            if (!in_req)
               check_reset_state();
         end
      end
      check_value("first in_req cycle", cycle_cnt, 10);
      push_random(6);
      wait_outputs(8);
      set_rate(3);
      wait_outputs(8);
      // Clear the history with zeros, then a single impulse per channel
      push_const(8, 0, 0);
      push_const(1, 4096, -8192);
      push_const(10, 0, 0);
      drain();
      push_random(200);
      for (int i = 0; i < 2; i++)
      begin
         push_const(10, 131071, -131072);
         push_const(10, -131072, 131071);
      end
      drain();
      // The level changes right after an out_valid, well before the next strobe
      bypass = 1'b1;
      model_byp = 1'b1;
      push_random(12);
      drain();
      bypass = 1'b0;
      model_byp = 1'b0;
      push_random(16);
      wait_inputs(8);
      drain();
      if (sat_hits > 0)
      begin
         $display("Result: PASSED");
         $finish;
      end
      else
      begin
         report_failure("The step stimulus never drove the filter into saturation");
      end
   end

endmodule

`default_nettype wire
